//--- hw/tap_creg_pkg.sv
/*
 * tap control-register bridge, shared definitions
 * UCB packet layout, request codes, widths and the JTAG command bundle
 * used by the jbus_clk side of the tap CSR path
 */

package tap_creg_pkg;

   // -------------------------------------------------------------------------
   // widths with a meaning of their own
   // -------------------------------------------------------------------------

   // physical address of a CSR access
   typedef logic [39:0] creg_addr_t;
   // one CSR data word
   typedef logic [63:0] creg_data_t;
   // one beat on either IOB link
   typedef logic [7:0]  ucb_byte_t;
   typedef logic [2:0]  ucb_size_t;
   typedef logic [1:0]  ucb_buf_id_t;
   typedef logic [5:0]  ucb_thr_id_t;
   // beats of one packet, 0 to 16
   typedef logic [4:0]  ucb_beat_cnt_t;

   // request codes in the low nibble of a packet
   typedef enum logic [3:0] {
      read_nack = 4'b0000,
      read_ack  = 4'b0001,
      write_ack = 4'b0010,
      read_req  = 4'b0100,
      write_req = 4'b0101
   } ucb_pkt_kind_e;

   // -------------------------------------------------------------------------
   // packet format, msb first
   // -------------------------------------------------------------------------

   typedef struct packed {
      creg_data_t    data;
      logic [8:0]    pad;
      creg_addr_t    addr;
      ucb_size_t     size;
      ucb_buf_id_t   buf_id;
      ucb_thr_id_t   thr_id;
      ucb_pkt_kind_e kind;
   } ucb_pkt_t;

   // fields the consumers of an inbound packet look at
   typedef struct packed {
      ucb_pkt_kind_e kind;
      creg_data_t    data;
      ucb_buf_id_t   buf_id;
      ucb_thr_id_t   thr_id;
   } ucb_in_t;

   // JTAG side, already in the jbus_clk domain
   typedef struct packed {
      creg_addr_t addr;
      creg_data_t data;
      logic       rd_en;
      logic       wr_en;
      logic       addr_en;
      logic       data_en;
   } jtag_creg_cmd_t;

   // -------------------------------------------------------------------------
   // constants
   // -------------------------------------------------------------------------

   // packet with a data word
   localparam ucb_beat_cnt_t UCB_BEATS_FULL = 5'd16;
   // header only, read request
   localparam ucb_beat_cnt_t UCB_BEATS_HDR  = 5'd8;
   // buffer id of the tap
   localparam ucb_buf_id_t   UCB_BID_TAP    = 2'b01;
   // 8 byte access
   localparam ucb_size_t     UCB_SZ_8B      = 3'b011;

endpackage

//--- hw/ucb_bus_in.sv
/*
 * inbound UCB byte collector
 * gathers a run of iob_tap_vld beats into a packet and pulses in_valid
 * with the decoded fields one cycle after the run ends
 */

`timescale 1ns/1ns

module ucb_bus_in (
   input  logic                      jbus_clk,
   input  logic                      rst_n,
   input  logic                      iob_tap_vld,
   input  tap_creg_pkg::ucb_byte_t   iob_tap_data,
   output logic                      in_valid,
   output tap_creg_pkg::ucb_in_t     in_pkt
);

   import tap_creg_pkg::*;

   logic [127:0]  rx_buf_q;
   ucb_beat_cnt_t beat_cnt_q;
   logic          in_valid_q;
   ucb_in_t       in_pkt_q;

   logic          run_end;
   logic [6:0]    byte_lsb;
   ucb_pkt_t      rx_pkt;

   // first idle cycle after at least one beat
   assign run_end  = ~iob_tap_vld & (beat_cnt_q != '0);
   // byte lane of the current beat
   assign byte_lsb = {beat_cnt_q[3:0], 3'b000};
   assign rx_pkt   = ucb_pkt_t'(rx_buf_q);

   // ------------------------------------------------------------------------
   // collect and decode
   // ------------------------------------------------------------------------
   always_ff @(posedge jbus_clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_buf_q   <= '0;
         beat_cnt_q <= '0;
         in_valid_q <= 1'b0;
         in_pkt_q   <= '0;
      end else begin
         in_valid_q <= run_end;
         if (iob_tap_vld) begin
            // lowest byte arrives first
            rx_buf_q[byte_lsb +: 8] <= iob_tap_data;
            beat_cnt_q              <= beat_cnt_q + 5'd1;
         end else begin
            beat_cnt_q <= '0;
         end
         if (run_end) begin
            in_pkt_q.kind   <= rx_pkt.kind;
            in_pkt_q.buf_id <= rx_pkt.buf_id;
            in_pkt_q.thr_id <= rx_pkt.thr_id;
            // header-only run leaves stale upper bytes
            in_pkt_q.data   <= (beat_cnt_q == UCB_BEATS_FULL) ? rx_pkt.data : '0;
         end
      end
   end

   // write_ack and unknown kinds pass through, consumers drop them
   assign in_valid = in_valid_q;
   assign in_pkt   = in_pkt_q;

   // IOB only sends whole packets
   ap_run_len: assert property (
      @(posedge jbus_clk) disable iff (!rst_n)
      run_end |-> (beat_cnt_q == UCB_BEATS_HDR || beat_cnt_q == UCB_BEATS_FULL)
   ) else $error("inbound run of %0d beats", beat_cnt_q);

endmodule

//--- hw/ucb_bus_out.sv
/*
 * outbound UCB byte sender
 * sends one packet lowest byte first, 8 beats for a read request and
 * 16 otherwise, and holds the beat while the IOB stalls
 */

`timescale 1ns/1ns

module ucb_bus_out (
   input  logic                       jbus_clk,
   input  logic                       rst_n,
   input  logic                       out_pkt_valid,
   input  tap_creg_pkg::ucb_pkt_t     out_pkt,
   input  logic                       iob_tap_stall,
   output logic                       out_pkt_ready,
   output logic                       tap_iob_vld,
   output tap_creg_pkg::ucb_byte_t    tap_iob_data
);

   import tap_creg_pkg::*;

   typedef enum logic {
      st_idle,
      st_send
   } out_state_e;

   out_state_e    state_q;
   logic [127:0]  shift_q;
   ucb_beat_cnt_t beats_left_q;

   logic          pkt_acpt;
   logic          beat;

   assign out_pkt_ready = (state_q == st_idle);
   assign pkt_acpt      = out_pkt_valid & out_pkt_ready;
   // a beat goes out only when not stalled
   assign beat          = (state_q == st_send) & ~iob_tap_stall;

   // ------------------------------------------------------------------------
   // sender FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge jbus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= st_idle;
         shift_q      <= '0;
         beats_left_q <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               if (pkt_acpt) begin
                  state_q <= st_send;
                  shift_q <= out_pkt;
                  // read request is header only
                  beats_left_q <= (out_pkt.kind == read_req) ? UCB_BEATS_HDR
                                                             : UCB_BEATS_FULL;
               end
            end
            st_send: begin
               if (beat) begin
                  shift_q      <= {8'h00, shift_q[127:8]};
                  beats_left_q <= beats_left_q - 5'd1;
                  // last beat
                  if (beats_left_q == 5'd1) begin
                     state_q <= st_idle;
                  end
               end
            end
            default: begin
               state_q <= st_idle;
            end
         endcase
      end
   end

   assign tap_iob_vld  = beat;
   // low byte of the shifter is the current beat
   assign tap_iob_data = shift_q[7:0];

endmodule

//--- hw/ucb_req_mux.sv
/*
 * outbound request mux with the tap scratch register
 * answers IOB reads with a read ack, stalls the IOB meanwhile, and
 * forwards JTAG requests when no ack is waiting
 */

`timescale 1ns/1ns

module ucb_req_mux (
   input  logic                      jbus_clk,
   input  logic                      rst_n,
   input  logic                      in_valid,
   input  tap_creg_pkg::ucb_in_t     in_pkt,
   input  logic                      jtag_pkt_valid,
   input  tap_creg_pkg::ucb_pkt_t    jtag_pkt,
   input  logic                      out_pkt_ready,
   output logic                      jtag_pkt_ready,
   output logic                      out_pkt_valid,
   output tap_creg_pkg::ucb_pkt_t    out_pkt,
   output logic                      tap_iob_stall,
   output tap_creg_pkg::creg_data_t  creg_jtag_scratch_data
);

   import tap_creg_pkg::*;

   creg_data_t  scratch_q;
   logic        ack_pend_q;
   ucb_buf_id_t ack_buf_id_q;
   ucb_thr_id_t ack_thr_id_q;
   // jtag packet offered but not yet taken
   logic        jtag_hold_q;

   logic        wr_in;
   logic        rd_in;
   logic        sel_ack;
   logic        ack_acpt;
   ucb_pkt_t    ack_pkt;

   // only one register here, so no address match
   assign wr_in = in_valid & (in_pkt.kind == write_req);
   assign rd_in = in_valid & (in_pkt.kind == read_req);

   // ack goes first, unless a jtag packet is already on offer
   assign sel_ack  = ack_pend_q & ~jtag_hold_q;
   assign ack_acpt = sel_ack & out_pkt_ready;

   // ------------------------------------------------------------------------
   // scratch, ack pending, offer lock
   // ------------------------------------------------------------------------
   always_ff @(posedge jbus_clk or negedge rst_n) begin
      if (!rst_n) begin
         scratch_q    <= '0;
         ack_pend_q   <= 1'b0;
         ack_buf_id_q <= '0;
         ack_thr_id_q <= '0;
         jtag_hold_q  <= 1'b0;
      end else begin
         if (wr_in) begin
            scratch_q <= in_pkt.data;
         end
         // remember who asked
         if (rd_in) begin
            ack_buf_id_q <= in_pkt.buf_id;
            ack_thr_id_q <= in_pkt.thr_id;
         end
         ack_pend_q  <= rd_in | (ack_pend_q & ~ack_acpt);
         jtag_hold_q <= ~sel_ack & jtag_pkt_valid & ~out_pkt_ready;
      end
   end

   // read ack carries the scratch value
   always_comb begin
      ack_pkt.data   = scratch_q;
      ack_pkt.pad    = '0;
      ack_pkt.addr   = '0;
      ack_pkt.size   = '0;
      ack_pkt.buf_id = ack_buf_id_q;
      ack_pkt.thr_id = ack_thr_id_q;
      ack_pkt.kind   = read_ack;
   end

   assign out_pkt_valid          = sel_ack | jtag_pkt_valid;
   assign out_pkt                = sel_ack ? ack_pkt : jtag_pkt;
   assign jtag_pkt_ready         = ~sel_ack & out_pkt_ready;
   // IOB holds off until the ack is taken
   assign tap_iob_stall          = ack_pend_q;
   assign creg_jtag_scratch_data = scratch_q;

   // offered packet does not change before the sender takes it
   ap_out_stable: assert property (
      @(posedge jbus_clk) disable iff (!rst_n)
      (out_pkt_valid && !out_pkt_ready) |=> $stable(out_pkt)
   ) else $error("out_pkt changed while waiting for out_pkt_ready");

endmodule

//--- hw/jtag_creg_ctl.sv
/*
 * JTAG side of the tap CSR bridge
 * captures address and data, turns rd_en / wr_en edges into UCB requests,
 * tracks the outstanding read and holds its return data for JTAG
 */

`timescale 1ns/1ns

module jtag_creg_ctl (
   input  logic                          jbus_clk,
   input  logic                          rst_n,
   input  tap_creg_pkg::jtag_creg_cmd_t  jtag_creg_cmd,
   input  logic                          jtag_creg_rdrtrn_complete,
   input  logic                          in_valid,
   input  tap_creg_pkg::ucb_in_t         in_pkt,
   input  logic                          jtag_pkt_ready,
   output logic                          jtag_pkt_valid,
   output tap_creg_pkg::ucb_pkt_t        jtag_pkt,
   output tap_creg_pkg::creg_data_t      creg_jtag_rdrtrn_data,
   output logic                          creg_jtag_rdrtrn_vld
);

   import tap_creg_pkg::*;

   creg_addr_t addr_q;
   creg_data_t data_q;
   logic       rd_en_d1;
   logic       wr_en_d1;
   logic       rd_req_q;
   logic       wr_req_q;
   logic       rd_pend_q;
   creg_data_t rdrtrn_data_q;
   logic       rdrtrn_vld_q;

   logic       rd_rise;
   logic       wr_rise;
   logic       req_acpt;
   logic       rdrtrn_in;

   // new request on the rising edge of the enable
   assign rd_rise   = jtag_creg_cmd.rd_en & ~rd_en_d1;
   assign wr_rise   = jtag_creg_cmd.wr_en & ~wr_en_d1;
   assign req_acpt  = jtag_pkt_valid & jtag_pkt_ready;
   // read return for us
   assign rdrtrn_in = in_valid & (in_pkt.kind == read_ack);

   // ------------------------------------------------------------------------
   // capture, request flags, read pending
   // ------------------------------------------------------------------------
   always_ff @(posedge jbus_clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q        <= '0;
         data_q        <= '0;
         rd_en_d1      <= 1'b0;
         wr_en_d1      <= 1'b0;
         rd_req_q      <= 1'b0;
         wr_req_q      <= 1'b0;
         rd_pend_q     <= 1'b0;
         rdrtrn_data_q <= '0;
         rdrtrn_vld_q  <= 1'b0;
      end else begin
         if (jtag_creg_cmd.addr_en) begin
            addr_q <= jtag_creg_cmd.addr;
         end
         if (jtag_creg_cmd.data_en) begin
            data_q <= jtag_creg_cmd.data;
         end
         rd_en_d1  <= jtag_creg_cmd.rd_en;
         wr_en_d1  <= jtag_creg_cmd.wr_en;
         // held until the mux takes it
         rd_req_q  <= rd_rise | (rd_req_q & ~req_acpt);
         wr_req_q  <= wr_rise | (wr_req_q & ~req_acpt);
         // waits for the read ack
         rd_pend_q <= (rd_req_q & req_acpt) | (rd_pend_q & ~rdrtrn_in);
         if (rd_pend_q && rdrtrn_in) begin
            rdrtrn_data_q <= in_pkt.data;
         end
         // stays up until JTAG says it has the data
         rdrtrn_vld_q <= ~jtag_creg_rdrtrn_complete
                         & ((rd_pend_q & rdrtrn_in) | rdrtrn_vld_q);
      end
   end

   // request packet
   always_comb begin
      jtag_pkt.data   = data_q;
      jtag_pkt.pad    = '0;
      jtag_pkt.addr   = addr_q;
      jtag_pkt.size   = UCB_SZ_8B;
      jtag_pkt.buf_id = UCB_BID_TAP;
      jtag_pkt.thr_id = '0;
      jtag_pkt.kind   = wr_req_q ? write_req : read_req;
   end

   assign jtag_pkt_valid        = rd_req_q | wr_req_q;
   assign creg_jtag_rdrtrn_data = rdrtrn_data_q;
   assign creg_jtag_rdrtrn_vld  = rdrtrn_vld_q;

   // one JTAG request at a time
   ap_one_req: assert property (
      @(posedge jbus_clk) disable iff (!rst_n)
      rd_req_q |-> !wr_req_q
   ) else $error("concurrent JTAG read and write request");

endmodule

//--- hw/tap_creg_top.sv
/*
 * tap control-register bridge, top level
 * joins the JTAG request logic, the outbound request mux and the two
 * byte-wide UCB links to the IOB
 */

`timescale 1ns/1ns

module tap_creg_top (
   input  logic                          jbus_clk,
   input  logic                          rst_n,

   // JTAG side
   input  tap_creg_pkg::jtag_creg_cmd_t  jtag_creg_cmd,
   input  logic                          jtag_creg_rdrtrn_complete,
   output tap_creg_pkg::creg_data_t      creg_jtag_scratch_data,
   output tap_creg_pkg::creg_data_t      creg_jtag_rdrtrn_data,
   output logic                          creg_jtag_rdrtrn_vld,

   // outbound link to the IOB
   output logic                          tap_iob_vld,
   output tap_creg_pkg::ucb_byte_t       tap_iob_data,
   input  logic                          iob_tap_stall,

   // inbound link from the IOB
   input  logic                          iob_tap_vld,
   input  tap_creg_pkg::ucb_byte_t       iob_tap_data,
   output logic                          tap_iob_stall
);

   import tap_creg_pkg::*;

   // JTAG request into the mux
   logic     jtag_pkt_valid;
   logic     jtag_pkt_ready;
   ucb_pkt_t jtag_pkt;

   // mux into the byte sender
   logic     out_pkt_valid;
   logic     out_pkt_ready;
   ucb_pkt_t out_pkt;

   // decoded inbound packet, one cycle pulse
   logic     in_valid;
   ucb_in_t  in_pkt;

   // -------------------------------------------------------------------------
   // JTAG requests and read return
   // -------------------------------------------------------------------------
   jtag_creg_ctl u_jtag_creg_ctl (
      .jbus_clk                  (jbus_clk),
      .rst_n                     (rst_n),
      .jtag_creg_cmd             (jtag_creg_cmd),
      .jtag_creg_rdrtrn_complete (jtag_creg_rdrtrn_complete),
      .in_valid                  (in_valid),
      .in_pkt                    (in_pkt),
      .jtag_pkt_ready            (jtag_pkt_ready),
      .jtag_pkt_valid            (jtag_pkt_valid),
      .jtag_pkt                  (jtag_pkt),
      .creg_jtag_rdrtrn_data     (creg_jtag_rdrtrn_data),
      .creg_jtag_rdrtrn_vld      (creg_jtag_rdrtrn_vld)
   );

   // scratch register, read ack and outbound choice
   ucb_req_mux u_ucb_req_mux (
      .jbus_clk               (jbus_clk),
      .rst_n                  (rst_n),
      .in_valid               (in_valid),
      .in_pkt                 (in_pkt),
      .jtag_pkt_valid         (jtag_pkt_valid),
      .jtag_pkt               (jtag_pkt),
      .out_pkt_ready          (out_pkt_ready),
      .jtag_pkt_ready         (jtag_pkt_ready),
      .out_pkt_valid          (out_pkt_valid),
      .out_pkt                (out_pkt),
      .tap_iob_stall          (tap_iob_stall),
      .creg_jtag_scratch_data (creg_jtag_scratch_data)
   );

   // -------------------------------------------------------------------------
   // byte links
   // -------------------------------------------------------------------------
   ucb_bus_out u_ucb_bus_out (
      .jbus_clk      (jbus_clk),
      .rst_n         (rst_n),
      .out_pkt_valid (out_pkt_valid),
      .out_pkt       (out_pkt),
      .iob_tap_stall (iob_tap_stall),
      .out_pkt_ready (out_pkt_ready),
      .tap_iob_vld   (tap_iob_vld),
      .tap_iob_data  (tap_iob_data)
   );

   ucb_bus_in u_ucb_bus_in (
      .jbus_clk     (jbus_clk),
      .rst_n        (rst_n),
      .iob_tap_vld  (iob_tap_vld),
      .iob_tap_data (iob_tap_data),
      .in_valid     (in_valid),
      .in_pkt       (in_pkt)
   );

endmodule

//--- verif/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 10 ns jbus_clk, rst_n held low for the first 3 cycles
 */

`timescale 1ns/1ns

module tb_clk_gen (
   output logic jbus_clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 5;

   initial begin
      jbus_clk = 1'b0;
      forever #HALF_PERIOD jbus_clk = ~jbus_clk;
   end

   // release away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge jbus_clk);
      @(negedge jbus_clk);
      rst_n = 1'b1;
   end

endmodule

//--- verif/tap_creg_tb.sv
/*
 * testbench for the tap control-register bridge
 * JTAG driver, IOB byte-link model with random stall, scratch model
 * and expected UCB packets
 */

`timescale 1ns/1ns

module tap_creg_tb;

   import tap_creg_pkg::*;

   localparam int BEAT_TIMEOUT = 60;
   localparam int WAIT_TIMEOUT = 20;
   localparam int QUIET_CYCLES = 24;

   logic           jbus_clk;
   logic           rst_n;
   jtag_creg_cmd_t jtag_creg_cmd;
   logic           jtag_creg_rdrtrn_complete;
   creg_data_t     creg_jtag_scratch_data;
   creg_data_t     creg_jtag_rdrtrn_data;
   logic           creg_jtag_rdrtrn_vld;
   logic           tap_iob_vld;
   ucb_byte_t      tap_iob_data;
   logic           iob_tap_stall;
   logic           iob_tap_vld;
   ucb_byte_t      iob_tap_data;
   logic           tap_iob_stall;

   // random back-pressure on the outbound link
   logic           stall_en = 1'b0;
   // scratch register as the IOB sees it
   creg_data_t     scratch_model;
   int             err_cnt;
   int             chk_cnt;
   int             test_cnt;
   int             fail_cnt;

   tb_clk_gen u_clk_gen (
      .jbus_clk (jbus_clk),
      .rst_n    (rst_n)
   );

   tap_creg_top dut0 (
      .jbus_clk                  (jbus_clk),
      .rst_n                     (rst_n),
      .jtag_creg_cmd             (jtag_creg_cmd),
      .jtag_creg_rdrtrn_complete (jtag_creg_rdrtrn_complete),
      .creg_jtag_scratch_data    (creg_jtag_scratch_data),
      .creg_jtag_rdrtrn_data     (creg_jtag_rdrtrn_data),
      .creg_jtag_rdrtrn_vld      (creg_jtag_rdrtrn_vld),
      .tap_iob_vld               (tap_iob_vld),
      .tap_iob_data              (tap_iob_data),
      .iob_tap_stall             (iob_tap_stall),
      .iob_tap_vld               (iob_tap_vld),
      .iob_tap_data              (iob_tap_data),
      .tap_iob_stall             (tap_iob_stall)
   );

   // stall roughly one cycle in three while enabled
   always @(negedge jbus_clk) begin
      iob_tap_stall <= stall_en ? ($urandom % 3 == 0) : 1'b0;
   end

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic check_pkt(input string name, input ucb_pkt_t got, input ucb_pkt_t exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_data(input string name, input creg_data_t got, input creg_data_t exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // ------------------------------------------------------------------------
   // IOB model
   // ------------------------------------------------------------------------

   // header only for a read request
   function automatic int beats_for(input ucb_pkt_kind_e kind);
      return (kind == read_req) ? 8 : 16;
   endfunction

   // gather outbound beats, sampled on the rising edge
   task automatic collect_pkt(input int need, output ucb_pkt_t pkt);
      logic [127:0] bits;
      int           beats;
      int           idle;
      bits  = '0;
      beats = 0;
      idle  = 0;
      while (beats < need && idle < BEAT_TIMEOUT) begin
         @(posedge jbus_clk);
         if (tap_iob_vld) begin
            bits[beats*8 +: 8] = tap_iob_data;
            beats++;
            idle = 0;
         end else begin
            idle++;
         end
      end
      if (beats < need) begin
         $display("timeout: only %0d of %0d outbound beats arrived", beats, need);
         err_cnt++;
      end
      pkt = ucb_pkt_t'(bits);
   endtask

   // nothing more may follow a packet
   task automatic expect_quiet(input string what);
      int extra;
      extra = 0;
      repeat (QUIET_CYCLES) begin
         @(posedge jbus_clk);
         if (tap_iob_vld) begin
            extra++;
         end
      end
      if (extra != 0) begin
         $display("unexpected %0d outbound beats after the %s", extra, what);
         err_cnt++;
      end
   endtask

   // inbound packet, lowest byte first, only once the stall is low
   task automatic send_pkt(input ucb_pkt_t pkt, input int beats);
      logic [127:0] bits;
      int           cnt;
      bits = pkt;
      cnt  = 0;
      @(negedge jbus_clk);
      while (tap_iob_stall && cnt < WAIT_TIMEOUT) begin
         @(negedge jbus_clk);
         cnt++;
      end
      if (tap_iob_stall) begin
         $display("timeout: tap_iob_stall never dropped before an inbound packet");
         err_cnt++;
      end
      for (int i = 0; i < beats; i++) begin
         iob_tap_vld  = 1'b1;
         iob_tap_data = bits[i*8 +: 8];
         @(negedge jbus_clk);
      end
      iob_tap_vld  = 1'b0;
      iob_tap_data = '0;
   endtask

   // ------------------------------------------------------------------------
   // JTAG driver
   // ------------------------------------------------------------------------
   task automatic jtag_write(input creg_addr_t addr, input creg_data_t data);
      @(negedge jbus_clk);
      jtag_creg_cmd.addr    = addr;
      jtag_creg_cmd.data    = data;
      jtag_creg_cmd.addr_en = 1'b1;
      jtag_creg_cmd.data_en = 1'b1;
      @(negedge jbus_clk);
      jtag_creg_cmd.addr_en = 1'b0;
      jtag_creg_cmd.data_en = 1'b0;
      jtag_creg_cmd.wr_en   = 1'b1;
      @(negedge jbus_clk);
      jtag_creg_cmd.wr_en   = 1'b0;
   endtask

   task automatic jtag_read(input creg_addr_t addr);
      @(negedge jbus_clk);
      jtag_creg_cmd.addr    = addr;
      jtag_creg_cmd.addr_en = 1'b1;
      @(negedge jbus_clk);
      jtag_creg_cmd.addr_en = 1'b0;
      jtag_creg_cmd.rd_en   = 1'b1;
      @(negedge jbus_clk);
      jtag_creg_cmd.rd_en   = 1'b0;
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt != errs_before) begin
         fail_cnt++;
      end
      $display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "ok" : "FAILED");
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   initial begin
      ucb_pkt_t   exp;
      ucb_pkt_t   got;
      creg_addr_t addr;
      creg_data_t data;
      int         errs;
      int         cnt;

      void'($urandom(32'h462e_f7d0));
      jtag_creg_cmd             = '0;
      jtag_creg_rdrtrn_complete = 1'b0;
      iob_tap_stall             = 1'b0;
      iob_tap_vld               = 1'b0;
      iob_tap_data              = '0;
      stall_en                  = 1'b0;
      scratch_model             = '0;
      err_cnt                   = 0;
      chk_cnt                   = 0;
      test_cnt                  = 0;
      fail_cnt                  = 0;

      // out of reset
      errs = err_cnt;
      cnt  = 0;
      @(negedge jbus_clk);
      while (!rst_n && cnt < WAIT_TIMEOUT) begin
         @(negedge jbus_clk);
         cnt++;
      end
      if (!rst_n) begin
         $display("timeout: reset never released");
         err_cnt++;
      end
      check_flag("tap_iob_vld", tap_iob_vld, 1'b0);
      check_flag("tap_iob_stall", tap_iob_stall, 1'b0);
      check_flag("creg_jtag_rdrtrn_vld", creg_jtag_rdrtrn_vld, 1'b0);
      check_data("creg_jtag_scratch_data", creg_jtag_scratch_data, '0);
      end_test("reset values", errs);

      // JTAG write under random stall
      errs     = err_cnt;
      addr     = creg_addr_t'({$urandom, $urandom});
      data     = {$urandom, $urandom};
      stall_en = 1'b1;
      jtag_write(addr, data);
      exp = '{data: data, pad: '0, addr: addr, size: UCB_SZ_8B,
              buf_id: UCB_BID_TAP, thr_id: '0, kind: write_req};
      collect_pkt(beats_for(exp.kind), got);
      check_pkt("write request packet", got, exp);
      stall_en = 1'b0;
      expect_quiet("write request");
      end_test("jtag write", errs);

      // JTAG read, header only, then the read return
      errs     = err_cnt;
      addr     = creg_addr_t'({$urandom, $urandom});
      stall_en = 1'b1;
      jtag_read(addr);
      exp = '{data: '0, pad: '0, addr: addr, size: UCB_SZ_8B,
              buf_id: UCB_BID_TAP, thr_id: '0, kind: read_req};
      collect_pkt(beats_for(exp.kind), got);
      check_pkt("read request packet", got, exp);
      stall_en = 1'b0;
      expect_quiet("read request");
      data = {$urandom, $urandom};
      exp  = '{data: data, pad: '0, addr: '0, size: UCB_SZ_8B,
               buf_id: UCB_BID_TAP, thr_id: '0, kind: read_ack};
      send_pkt(exp, beats_for(exp.kind));
      cnt = 0;
      while (!creg_jtag_rdrtrn_vld && cnt < WAIT_TIMEOUT) begin
         @(negedge jbus_clk);
         cnt++;
      end
      check_flag("creg_jtag_rdrtrn_vld", creg_jtag_rdrtrn_vld, 1'b1);
      check_data("creg_jtag_rdrtrn_data", creg_jtag_rdrtrn_data, data);
      // held until JTAG completes
      repeat (2 + $urandom % 4) @(negedge jbus_clk);
      check_flag("creg_jtag_rdrtrn_vld", creg_jtag_rdrtrn_vld, 1'b1);
      jtag_creg_rdrtrn_complete = 1'b1;
      @(negedge jbus_clk);
      jtag_creg_rdrtrn_complete = 1'b0;
      check_flag("creg_jtag_rdrtrn_vld", creg_jtag_rdrtrn_vld, 1'b0);
      end_test("jtag read", errs);

      // IOB write to the scratch register
      errs = err_cnt;
      data = {$urandom, $urandom};
      exp  = '{data: data, pad: '0, addr: creg_addr_t'({$urandom, $urandom}),
               size: UCB_SZ_8B, buf_id: ucb_buf_id_t'($urandom),
               thr_id: ucb_thr_id_t'($urandom), kind: write_req};
      send_pkt(exp, beats_for(exp.kind));
      @(negedge jbus_clk);
      check_data("creg_jtag_scratch_data", creg_jtag_scratch_data, scratch_model);
      scratch_model = data;
      @(negedge jbus_clk);
      check_data("creg_jtag_scratch_data", creg_jtag_scratch_data, scratch_model);
      end_test("iob scratch write", errs);

      // IOB read of the scratch register, answered with a read ack
      errs     = err_cnt;
      stall_en = 1'b1;
      exp = '{data: '0, pad: '0, addr: creg_addr_t'({$urandom, $urandom}),
              size: UCB_SZ_8B, buf_id: ucb_buf_id_t'($urandom),
              thr_id: ucb_thr_id_t'($urandom), kind: read_req};
      send_pkt(exp, beats_for(exp.kind));
      cnt = 0;
      while (!tap_iob_stall && cnt < WAIT_TIMEOUT) begin
         @(negedge jbus_clk);
         cnt++;
      end
      check_flag("tap_iob_stall", tap_iob_stall, 1'b1);
      exp = '{data: scratch_model, pad: '0, addr: '0, size: '0,
              buf_id: exp.buf_id, thr_id: exp.thr_id, kind: read_ack};
      collect_pkt(beats_for(exp.kind), got);
      check_pkt("read ack packet", got, exp);
      stall_en = 1'b0;
      @(negedge jbus_clk);
      check_flag("tap_iob_stall", tap_iob_stall, 1'b0);
      expect_quiet("read ack");
      end_test("iob scratch read", errs);

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_cnt, fail_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- list.f
hw/tap_creg_pkg.sv
hw/ucb_bus_in.sv
hw/ucb_bus_out.sv
hw/ucb_req_mux.sv
hw/jtag_creg_ctl.sv
hw/tap_creg_top.sv
verif/tb_clk_gen.sv
verif/tap_creg_tb.sv
